/* hw/x_macros.svh */
/*
 * execute stage parameters
 * address and data widths, number of ALU lanes
 */

`ifndef X_MACROS_SVH
`define X_MACROS_SVH

// --------------------
// datapath widths
// --------------------

// pc and branch target width
`define X_ADDR_BITS 32

// operand and result width
`define X_DATA_BITS 32

// --------------------
// lane count
// --------------------

// two or more ALU lanes
`define X_NUM_LANES 2

`endif

/* hw/isa_pkg.sv */
/*
 * RV32 architectural types seen by the execute stage
 * micro-op encoding and pc, data and register index vectors
 */

`include "x_macros.svh"

package isa_pkg;

  // pc or branch target
  typedef logic [`X_ADDR_BITS-1:0] addr_t;

  // operand or result
  typedef logic [`X_DATA_BITS-1:0] data_t;

  // architectural register index
  typedef logic [4:0] reg_addr_t;

  // supported micro-ops
  typedef enum logic [3:0] {
    // arithmetic and logic
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLT,
    OP_SLTU,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    // conditional branches
    OP_BEQ,
    OP_BNE,
    OP_BLT,
    OP_BGE,
    // unconditional jump
    OP_JAL
  } rv_uop;

endpackage

/* hw/x_pipe_pkg.sv */
/*
 * execute stage internal types
 * lane pointer and lane occupancy state
 */

`include "x_macros.svh"

package x_pipe_pkg;

  // points at one lane
  typedef logic [$clog2(`X_NUM_LANES)-1:0] lane_idx_t;

  // one-entry lane occupancy
  typedef enum logic {
    LANE_EMPTY,
    LANE_FULL
  } lane_state_e;

endpackage

/* hw/x_stage_if.sv */
/*
 * execute stage lane buses
 * x_issue_if carries a decoded micro-op into a lane
 * x_result_if carries the lane result out to the collector
 */

`timescale 1ns/1ps

// --------------------
// issue bus
// --------------------

interface x_issue_if;

  logic               val;
  logic               rdy;
  isa_pkg::addr_t     pc;
  isa_pkg::data_t     op1;
  isa_pkg::data_t     op2;
  isa_pkg::reg_addr_t waddr;
  isa_pkg::rv_uop     uop;

  // transfer on val and rdy both high
  modport dispatch (
    output val, pc, op1, op2, waddr, uop,
    input  rdy
  );

  modport lane (
    input  val, pc, op1, op2, waddr, uop,
    output rdy
  );

endinterface

// --------------------
// result bus
// --------------------

interface x_result_if;

  logic               val;
  isa_pkg::data_t     wdata;
  isa_pkg::reg_addr_t waddr;
  logic               wen;
  logic               taken;
  isa_pkg::addr_t     target;
  // one-cycle acknowledge from collector
  logic               take;
  // drop whatever the lane holds
  logic               flush;

  modport lane (
    output val, wdata, waddr, wen, taken, target,
    input  take, flush
  );

  modport collector (
    input  val, wdata, waddr, wen, taken, target,
    output take, flush
  );

endinterface

/* hw/x_dispatch.sv */
/*
 * in-order issue of decode messages
 * round-robin over the ALU lanes, pointer cleared on squash
 */

`timescale 1ns/1ps

`include "x_macros.svh"

module x_dispatch (
  input  logic               clk,
  input  logic               rst,
  // decode stream
  input  logic               dx_val,
  output logic               dx_rdy,
  input  isa_pkg::addr_t     dx_pc,
  input  isa_pkg::data_t     dx_op1,
  input  isa_pkg::data_t     dx_op2,
  input  isa_pkg::reg_addr_t dx_waddr,
  input  isa_pkg::rv_uop     dx_uop,
  // from collector
  input  logic               squash,
  x_issue_if.dispatch        lanes [`X_NUM_LANES]
);

  import isa_pkg::*;
  import x_pipe_pkg::*;

  localparam lane_idx_t LAST_LANE = lane_idx_t'(`X_NUM_LANES - 1);

  lane_idx_t                issue_ptr;
  logic [`X_NUM_LANES-1:0]  lane_rdy;
  logic                     accept;

  // --------------------
  // lane fan-out
  // --------------------

  for (genvar g = 0; g < `X_NUM_LANES; g++) begin : g_lane
    // only the lane under the pointer sees val
    assign lanes[g].val   = dx_val && !squash && (issue_ptr == lane_idx_t'(g));
    assign lanes[g].pc    = dx_pc;
    assign lanes[g].op1   = dx_op1;
    assign lanes[g].op2   = dx_op2;
    assign lanes[g].waddr = dx_waddr;
    assign lanes[g].uop   = dx_uop;
    assign lane_rdy[g]    = lanes[g].rdy;
  end

  // no new work in the squash cycle
  assign dx_rdy = lane_rdy[issue_ptr] && !squash;
  assign accept = dx_val && dx_rdy;

  // --------------------
  // issue pointer
  // --------------------

  always_ff @(posedge clk) begin
    if (rst || squash) begin
      issue_ptr <= '0;
    end else if (accept) begin
      // wrap after the last lane
      issue_ptr <= (issue_ptr == LAST_LANE) ? '0 : issue_ptr + 1'b1;
    end
  end

  // pointer stays inside the lane array
  a_ptr_range: assert property (@(posedge clk) disable iff (rst)
    issue_ptr <= LAST_LANE);

endmodule

/* hw/x_alu_lane.sv */
/*
 * one-entry ALU lane
 * computes the result or resolves the branch on issue
 * holds it until the collector takes it or a flush drops it
 */

`timescale 1ns/1ps

`include "x_macros.svh"

module x_alu_lane (
  input  logic     clk,
  input  logic     rst,
  x_issue_if.lane  issue,
  x_result_if.lane result
);

  import isa_pkg::*;
  import x_pipe_pkg::*;

  localparam int SHAMT_BITS = $clog2(`X_DATA_BITS);

  lane_state_e state;
  logic        issue_fire;

  // next result, from the issue bus
  data_t       alu_wdata;
  logic        alu_wen;
  logic        alu_taken;
  addr_t       alu_target;
  logic [SHAMT_BITS-1:0] shamt;

  // registered result
  data_t       wdata_q;
  reg_addr_t   waddr_q;
  logic        wen_q;
  logic        taken_q;
  addr_t       target_q;

  assign issue.rdy  = (state == LANE_EMPTY);
  assign issue_fire = issue.val && issue.rdy;
  assign shamt      = issue.op2[SHAMT_BITS-1:0];

  // --------------------
  // ALU and branch unit
  // --------------------

  always_comb begin
    alu_wdata  = '0;
    alu_wen    = 1'b1;
    alu_taken  = 1'b0;
    // pc-relative, op2 holds the offset
    alu_target = issue.pc + addr_t'(issue.op2);
    unique case (issue.uop)
      OP_ADD:  alu_wdata = issue.op1 + issue.op2;
      OP_SUB:  alu_wdata = issue.op1 - issue.op2;
      OP_AND:  alu_wdata = issue.op1 & issue.op2;
      OP_OR:   alu_wdata = issue.op1 | issue.op2;
      OP_XOR:  alu_wdata = issue.op1 ^ issue.op2;
      OP_SLT:  alu_wdata = data_t'($signed(issue.op1) < $signed(issue.op2));
      OP_SLTU: alu_wdata = data_t'(issue.op1 < issue.op2);
      OP_SLL:  alu_wdata = issue.op1 << shamt;
      OP_SRL:  alu_wdata = issue.op1 >> shamt;
      OP_SRA:  alu_wdata = data_t'($signed(issue.op1) >>> shamt);
      // branches never write a register
      OP_BEQ: begin
        alu_wen   = 1'b0;
        alu_taken = (issue.op1 == issue.op2);
      end
      OP_BNE: begin
        alu_wen   = 1'b0;
        alu_taken = (issue.op1 != issue.op2);
      end
      OP_BLT: begin
        alu_wen   = 1'b0;
        alu_taken = ($signed(issue.op1) < $signed(issue.op2));
      end
      OP_BGE: begin
        alu_wen   = 1'b0;
        alu_taken = ($signed(issue.op1) >= $signed(issue.op2));
      end
      // link address goes to waddr
      OP_JAL: begin
        alu_wdata = data_t'(issue.pc + addr_t'(4));
        alu_taken = 1'b1;
      end
      default: alu_wen = 1'b0;
    endcase
  end

  // --------------------
  // occupancy
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= LANE_EMPTY;
    end else if (result.take || result.flush) begin
      state <= LANE_EMPTY;
    end else if (issue_fire) begin
      state <= LANE_FULL;
    end
  end

  // result held while full
  always_ff @(posedge clk) begin
    if (issue_fire) begin
      wdata_q  <= alu_wdata;
      waddr_q  <= issue.waddr;
      wen_q    <= alu_wen;
      taken_q  <= alu_taken;
      target_q <= alu_target;
    end
  end

  assign result.val    = (state == LANE_FULL);
  assign result.wdata  = wdata_q;
  assign result.waddr  = waddr_q;
  assign result.wen    = wen_q;
  assign result.taken  = taken_q;
  assign result.target = target_q;

  // empty and full are exclusive
  a_rdy_val: assert property (@(posedge clk) disable iff (rst)
    !(issue.rdy && result.val));

  // back-pressure keeps the result frozen
  a_hold: assert property (@(posedge clk) disable iff (rst)
    (result.val && !result.take && !result.flush) |=>
      (result.val && $stable(result.wdata) && $stable(result.waddr) &&
       $stable(result.wen) && $stable(result.taken) && $stable(result.target)));

endmodule

/* hw/x_collector.sv */
/*
 * in-order drain of the ALU lanes to writeback
 * a taken result squashes decode and flushes every lane
 */

`timescale 1ns/1ps

`include "x_macros.svh"

module x_collector (
  input  logic               clk,
  input  logic               rst,
  x_result_if.collector      lanes [`X_NUM_LANES],
  // writeback stream
  output logic               xw_val,
  input  logic               xw_rdy,
  output isa_pkg::reg_addr_t xw_waddr,
  output isa_pkg::data_t     xw_wdata,
  output logic               xw_wen,
  // back to decode
  output logic               squash,
  output isa_pkg::addr_t     branch_target
);

  import isa_pkg::*;
  import x_pipe_pkg::*;

  localparam lane_idx_t LAST_LANE = lane_idx_t'(`X_NUM_LANES - 1);

  lane_idx_t drain_ptr;
  logic      xfer;

  // gathered lane outputs
  logic      lane_val    [`X_NUM_LANES];
  data_t     lane_wdata  [`X_NUM_LANES];
  reg_addr_t lane_waddr  [`X_NUM_LANES];
  logic      lane_wen    [`X_NUM_LANES];
  logic      lane_taken  [`X_NUM_LANES];
  addr_t     lane_target [`X_NUM_LANES];

  // --------------------
  // lane fan-in
  // --------------------

  for (genvar g = 0; g < `X_NUM_LANES; g++) begin : g_lane
    assign lane_val[g]    = lanes[g].val;
    assign lane_wdata[g]  = lanes[g].wdata;
    assign lane_waddr[g]  = lanes[g].waddr;
    assign lane_wen[g]    = lanes[g].wen;
    assign lane_taken[g]  = lanes[g].taken;
    assign lane_target[g] = lanes[g].target;
    // ack only the oldest lane
    assign lanes[g].take  = xfer && (drain_ptr == lane_idx_t'(g));
    // broadcast so every younger op is dropped
    assign lanes[g].flush = squash;
  end

  // --------------------
  // writeback select
  // --------------------

  assign xw_val   = lane_val[drain_ptr];
  assign xw_waddr = lane_waddr[drain_ptr];
  assign xw_wdata = lane_wdata[drain_ptr];
  // register write only while a result is valid
  assign xw_wen   = xw_val && lane_wen[drain_ptr];
  assign xfer     = xw_val && xw_rdy;

  // redirect
  assign squash        = xfer && lane_taken[drain_ptr];
  assign branch_target = squash ? lane_target[drain_ptr] : '0;

  always_ff @(posedge clk) begin
    if (rst || squash) begin
      drain_ptr <= '0;
    end else if (xfer) begin
      drain_ptr <= (drain_ptr == LAST_LANE) ? '0 : drain_ptr + 1'b1;
    end
  end

  // squash rides on a transfer and leaves the stage empty
  a_squash: assert property (@(posedge clk) disable iff (rst)
    squash |-> (xw_val && xw_rdy) ##1 !xw_val);

endmodule

/* hw/execute_cluster.sv */
/*
 * RV32 execute stage top level
 * dispatch, a generated row of ALU lanes, in-order collector
 */

`timescale 1ns/1ps

`include "x_macros.svh"

module execute_cluster (
  input  logic               clk,
  input  logic               rst,
  // decode stream
  input  logic               dx_val,
  output logic               dx_rdy,
  input  isa_pkg::addr_t     dx_pc,
  input  isa_pkg::data_t     dx_op1,
  input  isa_pkg::data_t     dx_op2,
  input  isa_pkg::reg_addr_t dx_waddr,
  input  isa_pkg::rv_uop     dx_uop,
  // writeback stream
  output logic               xw_val,
  input  logic               xw_rdy,
  output isa_pkg::reg_addr_t xw_waddr,
  output isa_pkg::data_t     xw_wdata,
  output logic               xw_wen,
  // redirect to decode
  output logic               squash,
  output isa_pkg::addr_t     branch_target
);

  import isa_pkg::*;
  import x_pipe_pkg::*;

  // one issue and one result bus per lane
  x_issue_if  issue_bus  [`X_NUM_LANES] ();
  x_result_if result_bus [`X_NUM_LANES] ();

  x_dispatch x_dispatch_i (
    .clk      (clk),
    .rst      (rst),
    .dx_val   (dx_val),
    .dx_rdy   (dx_rdy),
    .dx_pc    (dx_pc),
    .dx_op1   (dx_op1),
    .dx_op2   (dx_op2),
    .dx_waddr (dx_waddr),
    .dx_uop   (dx_uop),
    .squash   (squash),
    .lanes    (issue_bus)
  );

  // --------------------
  // ALU lanes
  // --------------------

  for (genvar g = 0; g < `X_NUM_LANES; g++) begin : g_lane
    x_alu_lane x_alu_lane_i (
      .clk    (clk),
      .rst    (rst),
      .issue  (issue_bus[g]),
      .result (result_bus[g])
    );
  end

  x_collector x_collector_i (
    .clk           (clk),
    .rst           (rst),
    .lanes         (result_bus),
    .xw_val        (xw_val),
    .xw_rdy        (xw_rdy),
    .xw_waddr      (xw_waddr),
    .xw_wdata      (xw_wdata),
    .xw_wen        (xw_wen),
    .squash        (squash),
    .branch_target (branch_target)
  );

endmodule

/* verification/execute_cluster_tb.sv */
/*
 * testbench for the RV32 execute stage
 * plays decode and writeback, keeps an in-order model of pending results
 */

`timescale 1ns/1ps

`include "x_macros.svh"

module execute_cluster_tb;

  import isa_pkg::*;

  localparam int NUM_LANES      = `X_NUM_LANES;
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int MSB            = `X_DATA_BITS - 1;

  // one predicted writeback
  typedef struct packed {
    logic      wen;
    reg_addr_t waddr;
    data_t     wdata;
    logic      taken;
    addr_t     target;
  } exp_t;

  logic      clk = 1'b0;
  logic      rst;
  logic      dx_val;
  logic      dx_rdy;
  addr_t     dx_pc;
  data_t     dx_op1;
  data_t     dx_op2;
  reg_addr_t dx_waddr;
  rv_uop     dx_uop;
  logic      xw_val;
  logic      xw_rdy;
  reg_addr_t xw_waddr;
  data_t     xw_wdata;
  logic      xw_wen;
  logic      squash;
  addr_t     branch_target;

  exp_t        exp_q [$];
  logic [31:0] rand_state = 32'd27081;
  logic [31:0] rdy_state  = 32'd27081;
  // 0 always ready, 1 random, 2 held low
  int          rdy_mode   = 0;
  int          checks     = 0;
  int          errors     = 0;
  int          retired    = 0;
  int          squash_seen = 0;
  int          full_seen  = 0;
  int          cycles     = 0;

  execute_cluster execute_cluster_i (
    .clk           (clk),
    .rst           (rst),
    .dx_val        (dx_val),
    .dx_rdy        (dx_rdy),
    .dx_pc         (dx_pc),
    .dx_op1        (dx_op1),
    .dx_op2        (dx_op2),
    .dx_waddr      (dx_waddr),
    .dx_uop        (dx_uop),
    .xw_val        (xw_val),
    .xw_rdy        (xw_rdy),
    .xw_waddr      (xw_waddr),
    .xw_wdata      (xw_wdata),
    .xw_wen        (xw_wen),
    .squash        (squash),
    .branch_target (branch_target)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // --------------------
  // random source
  // --------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] rand32();
    rand_state = xorshift32(rand_state);
    return rand_state;
  endfunction

  // --------------------
  // reference model
  // --------------------

  function automatic exp_t predict(input rv_uop uop, input addr_t pc, input data_t a,
                                   input data_t b, input reg_addr_t rd);
    exp_t       e;
    logic [4:0] sh;
    logic       lt;
    data_t      ones;
    sh       = b[4:0];
    ones     = '1;
    // signed less-than from the sign bits
    lt       = (a[MSB] != b[MSB]) ? a[MSB] : (a < b);
    e.wen    = 1'b1;
    e.waddr  = rd;
    e.wdata  = '0;
    e.taken  = 1'b0;
    e.target = pc + addr_t'(b);
    case (uop)
      OP_ADD:  e.wdata = a + b;
      OP_SUB:  e.wdata = a - b;
      OP_AND:  e.wdata = a & b;
      OP_OR:   e.wdata = a | b;
      OP_XOR:  e.wdata = a ^ b;
      OP_SLT:  e.wdata = data_t'(lt);
      OP_SLTU: e.wdata = data_t'(a < b);
      OP_SLL:  e.wdata = a << sh;
      OP_SRL:  e.wdata = a >> sh;
      // fill the vacated top bits with the sign
      OP_SRA:  e.wdata = (a >> sh) | (a[MSB] ? ~(ones >> sh) : '0);
      OP_BEQ: begin
        e.wen   = 1'b0;
        e.taken = (a == b);
      end
      OP_BNE: begin
        e.wen   = 1'b0;
        e.taken = (a != b);
      end
      OP_BLT: begin
        e.wen   = 1'b0;
        e.taken = lt;
      end
      OP_BGE: begin
        e.wen   = 1'b0;
        e.taken = !lt;
      end
      OP_JAL: begin
        e.wdata = data_t'(pc + addr_t'(4));
        e.taken = 1'b1;
      end
      default: e.wen = 1'b0;
    endcase
    return e;
  endfunction

  // --------------------
  // compare tasks
  // --------------------

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail at %0d ns: %s expected %0b got %0b", $time, name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail at %0d ns: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail at %0d ns: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail at %0d ns: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  // --------------------
  // monitor
  // --------------------

  // sampled mid-cycle while every value is stable
  always @(negedge clk) begin : monitor
    exp_t head;
    logic exp_squash;
    if (!rst) begin
      exp_squash = xw_val && xw_rdy && (exp_q.size() != 0) && exp_q[0].taken;
      check_bit("xw_val", exp_q.size() != 0, xw_val);
      // lane under issue_ptr is empty unless every lane holds an op
      check_bit("dx_rdy", (exp_q.size() < NUM_LANES) && !exp_squash, dx_rdy);
      check_bit("squash", exp_squash, squash);
      if (exp_q.size() == NUM_LANES) begin
        full_seen++;
      end
      if (!exp_squash) begin
        check_addr("branch_target", '0, branch_target);
      end
      if (xw_val && xw_rdy) begin
        if (exp_q.size() == 0) begin
          report_error("writeback transfer with no op in flight");
        end else begin
          head = exp_q.pop_front();
          check_bit("xw_wen", head.wen, xw_wen);
          if (head.wen) begin
            check_reg("xw_waddr", head.waddr, xw_waddr);
            check_data("xw_wdata", head.wdata, xw_wdata);
            retired++;
          end
          // everything still queued is younger than the redirect
          if (head.taken) begin
            check_addr("branch_target", head.target, branch_target);
            exp_q.delete();
            squash_seen++;
          end
        end
      end
      if (dx_val && dx_rdy) begin
        exp_q.push_back(predict(dx_uop, dx_pc, dx_op1, dx_op2, dx_waddr));
      end
    end
  end

  // writeback ready pattern
  initial begin : rdy_driver
    xw_rdy = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      rdy_state = xorshift32(rdy_state);
      case (rdy_mode)
        1:       xw_rdy = rdy_state[3];
        2:       xw_rdy = 1'b0;
        default: xw_rdy = 1'b1;
      endcase
    end
  end

  always @(posedge clk) begin : watchdog
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // --------------------
  // drive helpers
  // --------------------

  // hold the message until decode sees dx_rdy
  task automatic send_op(input rv_uop uop, input addr_t pc, input data_t op1,
                         input data_t op2, input reg_addr_t waddr);
    logic accepted;
    accepted = 1'b0;
    dx_val   = 1'b1;
    dx_uop   = uop;
    dx_pc    = pc;
    dx_op1   = op1;
    dx_op2   = op2;
    dx_waddr = waddr;
    while (!accepted) begin
      @(negedge clk);
      accepted = dx_rdy;
      @(posedge clk);
      #1;
    end
    dx_val = 1'b0;
  endtask

  task automatic send_random_alu(input rv_uop uop);
    data_t     a;
    data_t     b;
    reg_addr_t rd;
    a  = rand32();
    b  = rand32();
    rd = reg_addr_t'(rand32());
    send_op(uop, addr_t'(rand32()), a, b, rd);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    #1;
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("%s: done, %0d errors", name, errors - err_before);
  endtask

  // --------------------
  // directed tests
  // --------------------

  task automatic run_reset_test();
    int e0;
    e0 = errors;
    @(negedge clk);
    check_bit("xw_val", 1'b0, xw_val);
    check_bit("squash", 1'b0, squash);
    check_bit("dx_rdy", 1'b1, dx_rdy);
    check_addr("branch_target", '0, branch_target);
    @(posedge clk);
    #1;
    report_test("reset", e0);
  endtask

  task automatic run_alu_test();
    int e0;
    int r0;
    e0 = errors;
    r0 = retired;
    rdy_mode = 0;
    for (int i = 0; i <= int'(OP_SRA); i++) begin
      send_random_alu(rv_uop'(i));
    end
    wait_drain();
    if (retired - r0 != int'(OP_SRA) + 1) begin
      report_error($sformatf("alu ops: %0d results written, not %0d", retired - r0,
                             int'(OP_SRA) + 1));
    end
    report_test("alu ops", e0);
  endtask

  task automatic run_backpressure_test();
    int e0;
    int r0;
    int f0;
    e0 = errors;
    r0 = retired;
    f0 = full_seen;
    rdy_mode = 1;
    repeat (40) begin
      send_random_alu(rv_uop'(4'(rand32() % 32'd10)));
    end
    wait_drain();
    rdy_mode = 0;
    if (retired - r0 != 40) begin
      report_error($sformatf("back-pressure: %0d of 40 results written", retired - r0));
    end
    if (full_seen == f0) begin
      report_error("back-pressure: the lanes never all filled up");
    end
    report_test("back-pressure", e0);
  endtask

  task automatic run_taken_branch_test();
    int e0;
    int r0;
    int s0;
    e0 = errors;
    r0 = retired;
    s0 = squash_seen;
    // hold the branch so younger ops pile up behind it
    rdy_mode = 2;
    send_op(OP_BEQ, 32'h0000_0200, 32'h1234, 32'h1234, 5'd0);
    for (int i = 1; i < NUM_LANES; i++) begin
      send_random_alu(OP_ADD);
    end
    rdy_mode = 0;
    send_random_alu(OP_XOR);
    wait_drain();
    if (squash_seen - s0 != 1) begin
      report_error($sformatf("taken branch: %0d squash pulses, not one", squash_seen - s0));
    end
    if (retired - r0 != 1) begin
      report_error("taken branch: flushed ops were written back");
    end
    report_test("taken branch", e0);
  endtask

  task automatic run_not_taken_test();
    int e0;
    int r0;
    int s0;
    e0 = errors;
    r0 = retired;
    s0 = squash_seen;
    send_op(OP_BNE, 32'h0000_0300, 32'h55, 32'h55, 5'd0);
    // -1 is below 1 as signed
    send_op(OP_BGE, 32'h0000_0304, 32'hffff_ffff, 32'h1, 5'd0);
    send_random_alu(OP_SUB);
    send_random_alu(OP_OR);
    wait_drain();
    if (squash_seen != s0) begin
      report_error("not-taken branch: squash was raised");
    end
    if (retired - r0 != 2) begin
      report_error("not-taken branch: following ops not retired");
    end
    report_test("not-taken branch", e0);
  endtask

  task automatic run_jal_test();
    int e0;
    int r0;
    int s0;
    e0 = errors;
    r0 = retired;
    s0 = squash_seen;
    rdy_mode = 2;
    send_op(OP_JAL, 32'h0000_0100, 32'h0, 32'h40, 5'd1);
    for (int i = 1; i < NUM_LANES; i++) begin
      send_random_alu(OP_AND);
    end
    rdy_mode = 0;
    send_random_alu(OP_SLL);
    wait_drain();
    if (squash_seen - s0 != 1) begin
      report_error("jal: no squash to the jump target");
    end
    // link write plus the op after the redirect
    if (retired - r0 != 2) begin
      report_error("jal: wrong number of writebacks");
    end
    report_test("jal", e0);
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin
    rst      = 1'b1;
    dx_val   = 1'b0;
    dx_pc    = '0;
    dx_op1   = '0;
    dx_op2   = '0;
    dx_waddr = '0;
    dx_uop   = OP_ADD;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    run_reset_test();
    run_alu_test();
    run_backpressure_test();
    run_taken_branch_test();
    run_not_taken_test();
    run_jal_test();
    $display("checks: %0d, errors: %0d, results written: %0d", checks, errors, retired);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+hw
hw/isa_pkg.sv
hw/x_pipe_pkg.sv
hw/x_stage_if.sv
hw/x_dispatch.sv
hw/x_alu_lane.sv
hw/x_collector.sv
hw/execute_cluster.sv
verification/execute_cluster_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module execute_cluster_tb \
  -f filelist.f -o execute_cluster_sim

out=$(./obj_dir/execute_cluster_sim)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1
